//--- common/icache_pkg.sv
`include "icache_settings.svh"

package icache_pkg;

	// Fetch address split into tag, set index and line offset.
	typedef struct packed {
		logic [`ICACHE_TAG_W-1:0]      tag;
		logic [`ICACHE_INDEX_W-1:0]    index;
		logic [`ICACHE_WORD_SEL_W-1:0] word;      // Instruction within the line.
		logic [`ICACHE_BYTE_OFF_W-1:0] byte_off;
	} fetch_addr_t;

	// A cache line is filled as one flat word and read one instruction at a time.
	typedef union packed {
		logic [`ICACHE_LINE_W-1:0]                         flat;
		logic [`ICACHE_WORDS-1:0][`ICACHE_INST_W-1:0]      words;
	} cache_line_u;

	// One-hot or zero, used for hit vectors and the victim pointer.
	typedef logic [`ICACHE_WAYS-1:0] way_vec_t;

endpackage

//--- common/icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// Geometry of the instruction cache.
`define ICACHE_ADDR_W 64                 // Fetch address width.
`define ICACHE_INDEX_W 6                 // 64 sets.
`define ICACHE_SETS (1 << `ICACHE_INDEX_W)
`define ICACHE_WAYS 4                    // One-hot way vector width.

`define ICACHE_INST_W 32
`define ICACHE_WORDS 4                   // Instructions per line.
`define ICACHE_LINE_W (`ICACHE_WORDS * `ICACHE_INST_W)

`define ICACHE_WORD_SEL_W 2
`define ICACHE_BYTE_OFF_W 2
`define ICACHE_OFFSET_W (`ICACHE_WORD_SEL_W + `ICACHE_BYTE_OFF_W)
`define ICACHE_TAG_W (`ICACHE_ADDR_W - `ICACHE_INDEX_W - `ICACHE_OFFSET_W)

`endif

//--- compile.f
+incdir+common
common/icache_pkg.sv
icache/icache_tag_array.sv
icache/icache_data_sram.sv
icache/icache.sv
hdl/icache_top.sv
sim/icache_properties.sv
sim/icache_tb.sv

//--- hdl/icache_top.sv
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache_top (
	input  logic                      clk,
	input  logic                      rst,
	input  icache_pkg::fetch_addr_t   addr,
	input  logic                      valid,
	input  logic                      flush,
	input  logic                      id_ready,
	output logic [`ICACHE_INST_W-1:0] inst,
	output logic                      ready,
	output logic                      mem_req,
	output icache_pkg::fetch_addr_t   mem_addr,
	input  icache_pkg::cache_line_u   mem_line
);

	// Fetch side on the left, backing memory line port on the right.
	icache core_i (
		.clk      (clk),
		.rst      (rst),
		.addr     (addr),
		.valid    (valid),
		.flush    (flush),
		.id_ready (id_ready),
		.inst     (inst),
		.ready    (ready),
		.mem_req  (mem_req),
		.mem_addr (mem_addr),
		.mem_line (mem_line)
	);

endmodule

//--- icache/icache.sv
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache (
	input  logic                      clk,
	input  logic                      rst,
	input  icache_pkg::fetch_addr_t   addr,
	input  logic                      valid,
	input  logic                      flush,
	input  logic                      id_ready,
	output logic [`ICACHE_INST_W-1:0] inst,
	output logic                      ready,
	output logic                      mem_req,
	output icache_pkg::fetch_addr_t   mem_addr,
	input  icache_pkg::cache_line_u   mem_line
);
	import icache_pkg::*;

	way_vec_t    way_hit;
	way_vec_t    victim;
	way_vec_t    hit_q;
	way_vec_t    way_cen;
	logic        miss;
	logic        fill;
	logic        accept;
	fetch_addr_t addr_q;
	cache_line_u line_q;
	cache_line_u line_sel;
	cache_line_u way_dout [`ICACHE_WAYS];

	assign miss   = valid && (way_hit == '0);
	assign fill   = miss && id_ready;      // Also on flush.
	assign accept = id_ready && !flush;

	// Memory answers in the same cycle.
	assign mem_req  = miss;
	assign mem_addr = addr;

	icache_tag_array tag_i (
		.clk     (clk),
		.rst     (rst),
		.lookup  (addr),
		.fill    (fill),
		.victim  (victim),
		.way_hit (way_hit)
	);

	// Read the hitting way, or write the victim way on a miss.
	always_comb begin
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			way_cen[w] = valid && id_ready && (way_hit[w] || (miss && victim[w]));
		end
	end

	for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
		icache_data_sram sram_i (
			.clk   (clk),
			.cen   (way_cen[w]),
			.wen   (miss),
			.index (addr.index),
			.din   (mem_line),
			.dout  (way_dout[w])
		);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			victim <= way_vec_t'(1);
			hit_q  <= '0;
			ready  <= 1'b0;
		end else if (id_ready) begin
			if (flush) begin
				hit_q <= '0;                 // Drop the pending output.
				ready <= 1'b0;
			end else begin
				victim <= {victim[`ICACHE_WAYS-2:0], victim[`ICACHE_WAYS-1]};
				hit_q  <= valid ? way_hit : '0;
				ready  <= valid;
			end
		end
	end

	// Miss line and address for the output stage.
	always_ff @(posedge clk) begin
		if (accept) begin
			addr_q <= addr;
			line_q <= mem_line;
		end
	end

	// Registered hitting way, else the line register.
	always_comb begin
		line_sel = line_q;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (hit_q[w]) begin
				line_sel = way_dout[w];
			end
		end
	end

	assign inst = line_sel.words[addr_q.word];

endmodule

//--- icache/icache_data_sram.sv
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache_data_sram (
	input  logic                       clk,
	input  logic                       cen,
	input  logic                       wen,
	input  logic [`ICACHE_INDEX_W-1:0] index,
	input  icache_pkg::cache_line_u    din,
	output icache_pkg::cache_line_u    dout
);
	import icache_pkg::*;

	cache_line_u mem [`ICACHE_SETS];

	// Single port, so a write cycle leaves dout untouched.
	always_ff @(posedge clk) begin
		if (cen) begin
			if (wen) begin
				mem[index] <= din;
			end else begin
				dout <= mem[index];
			end
		end
	end

endmodule

//--- icache/icache_tag_array.sv
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache_tag_array (
	input  logic                    clk,
	input  logic                    rst,
	input  icache_pkg::fetch_addr_t lookup,
	input  logic                    fill,
	input  icache_pkg::way_vec_t    victim,
	output icache_pkg::way_vec_t    way_hit
);
	import icache_pkg::*;

	logic [`ICACHE_TAG_W-1:0] tag_mem [`ICACHE_WAYS][`ICACHE_SETS];
	logic [`ICACHE_SETS-1:0]  valid_bits [`ICACHE_WAYS];
	way_vec_t                 fill_way;

	// Only the victim way takes the new line.
	assign fill_way = fill ? victim : '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				valid_bits[w] <= '0;
			end
		end else begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				if (fill_way[w]) begin
					valid_bits[w][lookup.index] <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (fill_way[w]) begin
				tag_mem[w][lookup.index] <= lookup.tag;
			end
		end
	end

	// All four ways are compared in parallel at the lookup index.
	always_comb begin
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			way_hit[w] = valid_bits[w][lookup.index] &&
				(tag_mem[w][lookup.index] == lookup.tag);
		end
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the instruction cache testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module icache_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vicache_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "ALL TESTS PASSED"; then
	exit 0
fi

echo "Pass message not found in the simulation output"
exit 1

//--- sim/icache_properties.sv
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache_properties (
	input logic                      clk,
	input logic                      rst,
	input icache_pkg::fetch_addr_t   addr,
	input logic                      id_ready,
	input logic                      mem_req,
	input logic                      ready,
	input logic [`ICACHE_INST_W-1:0] inst,
	input icache_pkg::way_vec_t      way_hit
);

	logic [`ICACHE_TAG_W+`ICACHE_INDEX_W-1:0] line_addr;

	assign line_addr = {addr.tag, addr.index};

	// A line lives in at most one way.
	hit_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(way_hit))
		else $error("way_hit has more than one way set");

	ready_after_reset: assert property (@(posedge clk) rst |=> !ready)
		else $error("ready is high in the cycle after reset");

	// A line filled at an edge hits at the next one.
	refill_hits: assert property (@(posedge clk) disable iff (rst)
		mem_req && id_ready |=> !mem_req || (line_addr != $past(line_addr)))
		else $error("mem_req is high again for the line filled at the previous edge");

	// Decode stall freezes the output stage.
	stall_holds: assert property (@(posedge clk) disable iff (rst)
		!id_ready |=> $stable(inst) && $stable(ready))
		else $error("inst or ready changed across a stalled cycle");

endmodule

bind icache icache_properties props_i (
	.clk      (clk),
	.rst      (rst),
	.addr     (addr),
	.id_ready (id_ready),
	.mem_req  (mem_req),
	.ready    (ready),
	.inst     (inst),
	.way_hit  (way_hit)
);

//--- sim/icache_tb.sv
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache_tb;
	import icache_pkg::*;

	localparam int clk_period     = 100;
	localparam int drive_delay    = 10;
	localparam int reset_cycles   = 10;
	localparam int random_fetches = 300;
	localparam int max_cycles     = 2000;     // About five times the length of all tests.

	logic                      clk;
	logic                      rst;
	fetch_addr_t               addr;
	logic                      valid;
	logic                      flush;
	logic                      id_ready;
	logic [`ICACHE_INST_W-1:0] inst;
	logic                      ready;
	logic                      mem_req;
	fetch_addr_t               mem_addr;
	cache_line_u               mem_line;

	// Reference cache state.
	logic [`ICACHE_TAG_W-1:0]         model_tag [`ICACHE_WAYS][`ICACHE_SETS];
	logic                             model_valid [`ICACHE_WAYS][`ICACHE_SETS];
	logic [$clog2(`ICACHE_WAYS)-1:0]  model_victim;
	logic                             exp_ready;
	logic [`ICACHE_INST_W-1:0]        exp_inst;
	logic [31:0]                      rnd_state;
	int                               errors;

	icache_top dut_i (
		.clk      (clk),
		.rst      (rst),
		.addr     (addr),
		.valid    (valid),
		.flush    (flush),
		.id_ready (id_ready),
		.inst     (inst),
		.ready    (ready),
		.mem_req  (mem_req),
		.mem_addr (mem_addr),
		.mem_line (mem_line)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_random();
		rnd_state = xorshift32(rnd_state);
		return rnd_state;
	endfunction

	// Every word gets a nonzero seed from its whole line address and its position.
	function automatic cache_line_u line_of(input fetch_addr_t a);
		cache_line_u                              line;
		logic [`ICACHE_TAG_W+`ICACHE_INDEX_W-1:0] line_addr;
		logic [27:0]                              folded;
		line_addr = {a.tag, a.index};
		folded = line_addr[27:0] ^ line_addr[55:28] ^ 28'(line_addr[59:56]);
		for (int w = 0; w < `ICACHE_WORDS; w++) begin
			line.words[w] = xorshift32({folded, 2'(w), 2'b01});
		end
		return line;
	endfunction

	// Backing memory answers in the same cycle, and drives junk when not asked.
	always_comb mem_line = mem_req ? line_of(mem_addr) : ~line_of(mem_addr);

	function automatic fetch_addr_t make_addr(input logic [31:0] tag, input logic [31:0] index,
		input logic [31:0] word);
		fetch_addr_t a;
		a = '0;
		a.tag[31:0] = tag;
		a.index = index[`ICACHE_INDEX_W-1:0];
		a.word = word[`ICACHE_WORD_SEL_W-1:0];
		return a;
	endfunction

	// Way holding the line, or -1 on a miss.
	function automatic int model_lookup(input fetch_addr_t a);
		int way;
		way = -1;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (model_valid[w][a.index] && (model_tag[w][a.index] == a.tag)) begin
				way = w;
			end
		end
		return way;
	endfunction

	task automatic model_reset();
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			for (int s = 0; s < `ICACHE_SETS; s++) begin
				model_valid[w][s] = 1'b0;
				model_tag[w][s] = '0;
			end
		end
		model_victim = '0;
		exp_ready = 1'b0;
		exp_inst = '0;
	endtask

	task automatic stop_on_error(input string what);
		errors++;
		$display("%s", what);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_inst(input logic [`ICACHE_INST_W-1:0] got,
		input logic [`ICACHE_INST_W-1:0] exp);
		if (got !== exp) begin
			stop_on_error($sformatf("mismatch inst: got %h, expected %h", got, exp));
		end
	endtask

	task automatic check_req(input logic got, input logic exp);
		if (got !== exp) begin
			stop_on_error($sformatf("mismatch mem_req: got %h, expected %h", got, exp));
		end
	endtask

	task automatic check_addr(input fetch_addr_t got, input fetch_addr_t exp);
		if (got !== exp) begin
			stop_on_error($sformatf("mismatch mem_addr: got %h, expected %h", got, exp));
		end
	endtask

	task automatic check_ready(input logic got, input logic exp);
		if (got !== exp) begin
			stop_on_error($sformatf("mismatch ready: got %h, expected %h", got, exp));
		end
	endtask

	task automatic drive(input fetch_addr_t a, input logic v, input logic f, input logic r);
		addr = a;
		valid = v;
		flush = f;
		id_ready = r;
	endtask

	// One clock. Starts and ends a short delay after a rising edge.
	task automatic cycle(input fetch_addr_t a, input logic v, input logic f, input logic r);
		int          hit_way;
		logic        exp_req;
		cache_line_u line_exp;
		drive(a, v, f, r);
		hit_way = model_lookup(a);
		exp_req = v && (hit_way < 0);
		@(negedge clk);
		check_req(mem_req, exp_req);
		if (exp_req) begin
			check_addr(mem_addr, a);
		end
		if (r) begin
			if (exp_req) begin                // Fill happens on flush too.
				model_tag[model_victim][a.index] = a.tag;
				model_valid[model_victim][a.index] = 1'b1;
			end
			if (f) begin
				exp_ready = 1'b0;
			end else begin
				line_exp = line_of(a);
				exp_ready = v;
				exp_inst = line_exp.words[a.word];
				model_victim = model_victim + 1'b1;
			end
		end
		@(posedge clk);
		#drive_delay;
		check_ready(ready, exp_ready);
		if (exp_ready) begin
			check_inst(inst, exp_inst);
		end
	endtask

	task automatic test_cold_miss();
		check_ready(ready, 1'b0);
		cycle(make_addr(1, 3, 2), 1'b1, 1'b0, 1'b1);
	endtask

	task automatic test_hit_words();
		for (int w = 0; w < `ICACHE_WORDS; w++) begin
			cycle(make_addr(1, 3, w), 1'b1, 1'b0, 1'b1);
		end
	endtask

	task automatic test_conflict();
		int evicted;
		evicted = -1;
		for (int t = 0; t < 5; t++) begin
			cycle(make_addr(32'h100 + t, 9, t % 4), 1'b1, 1'b0, 1'b1);
		end
		for (int t = 0; t < 5; t++) begin
			if (model_lookup(make_addr(32'h100 + t, 9, 0)) < 0) begin
				evicted = t;
			end
		end
		if (evicted < 0) begin
			stop_on_error("The model kept all five conflicting lines in a four-way set");
		end
		cycle(make_addr(32'h100 + evicted, 9, 1), 1'b1, 1'b0, 1'b1);   // Refill.
		cycle(make_addr(32'h100 + evicted, 9, 3), 1'b1, 1'b0, 1'b1);
	endtask

	task automatic test_stall();
		logic [`ICACHE_INST_W-1:0] held_inst;
		cycle(make_addr(3, 12, 1), 1'b1, 1'b0, 1'b1);
		held_inst = inst;
		for (int n = 0; n < 5; n++) begin
			cycle(make_addr(32'h40 + n, 12, 2), 1'b1, 1'b0, 1'b0);   // No fill while stalled.
		end
		check_ready(ready, 1'b1);
		check_inst(inst, held_inst);
		cycle(make_addr(3, 12, 3), 1'b1, 1'b0, 1'b1);
		cycle(make_addr(32'h40, 12, 0), 1'b1, 1'b0, 1'b1);
	endtask

	task automatic test_flush();
		cycle(make_addr(5, 20, 1), 1'b1, 1'b1, 1'b1);
		cycle(make_addr(5, 20, 2), 1'b1, 1'b0, 1'b1);
		cycle(make_addr(5, 21, 0), 1'b1, 1'b1, 1'b1);
		cycle('0, 1'b0, 1'b0, 1'b1);
		cycle(make_addr(5, 21, 3), 1'b1, 1'b0, 1'b1);
	endtask

	// Addresses stay within 4 KB, so sets see repeated tags.
	task automatic test_random();
		logic [31:0] r;
		fetch_addr_t a;
		for (int n = 0; n < random_fetches; n++) begin
			r = next_random();
			a = '0;
			a[11:2] = r[11:2];
			cycle(a, r[20] | r[21], 1'b0, r[24] | r[25]);
		end
	endtask

	initial begin
		errors = 0;
		rnd_state = 32'h2480;
		rst = 1'b1;
		drive('0, 1'b0, 1'b0, 1'b1);
		model_reset();
		repeat (reset_cycles) @(posedge clk);
		#drive_delay;
		rst = 1'b0;
		test_cold_miss();
		test_hit_words();
		test_conflict();
		test_stall();
		test_flush();
		test_random();
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	initial begin
		repeat (max_cycles) @(posedge clk);
		$display("Timeout: the tests did not finish within %0d cycles", max_cycles);
		$display("SOME TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule
